//--- common/ctrl_cfg.svh
`ifndef CTRL_CFG_SVH
`define CTRL_CFG_SVH

// instruction field widths
`define OPCODE_W 6
`define FUNCT_W 6

// opcode encodings
`define OP_RTYPE 6'b000000
`define OP_ADDI 6'b001000

// funct encodings, only meaningful when opcode is R-type
`define FN_ADD 6'b100000
`define FN_SUB 6'b100010

// memory latency seen by the fetch sequence
`define FETCH_READ_CYCLES 3

// step counter must reach FETCH_READ_CYCLES + 1
`define STEP_W 3

`endif

//--- common/ctrl_pkg.sv
`include "ctrl_cfg.svh"

package ctrl_pkg;

  // decoded instruction, CLS_NONE covers everything unsupported
  typedef enum logic [1:0] {
    CLS_ADD  = 2'd0,
    CLS_SUB  = 2'd1,
    CLS_ADDI = 2'd2,
    CLS_NONE = 2'd3
  } instrClass_t;

  typedef enum logic [2:0] {
    STG_RESET  = 3'd0,
    STG_FETCH  = 3'd1,
    STG_DECODE = 3'd2,
    STG_EXEC   = 3'd3,
    STG_WRITE  = 3'd4,
    STG_DONE   = 3'd5
  } stage_t;

  // registered sequencer state
  typedef struct packed {
    stage_t              stage;
    logic [`STEP_W-1:0]  step;       // sub-step inside fetch
    instrClass_t         instrClass; // latched at decode
  } phase_t;

  typedef enum logic [2:0] {
    ALU_NOP = 3'd0,
    ALU_ADD = 3'd1,
    ALU_SUB = 3'd2
  } aluOp_t;

  typedef enum logic [1:0] {
    SRCA_PC = 2'd0,
    SRCA_A  = 2'd1
  } aluSrcA_t;

  typedef enum logic [1:0] {
    SRCB_B    = 2'd0,
    SRCB_FOUR = 2'd1,
    SRCB_IMM  = 2'd2  // sign-extended immediate
  } aluSrcB_t;

  typedef enum logic [1:0] {
    DST_RT = 2'd0,
    DST_RD = 2'd1
  } regDst_t;

  // write-back mux, only the ALUOut leg is used here
  typedef enum logic [2:0] {
    WB_ALUOUT = 3'd1
  } memToReg_t;

  typedef enum logic [2:0] {
    PCS_NONE      = 3'd0,
    PCS_ALURESULT = 3'd1,
    PCS_ALUOUT    = 3'd2
  } pcSource_t;

  // everything the datapath needs in one cycle
  typedef struct packed {
    logic      pcWrite;
    logic      irWrite;
    logic      regWrite;
    logic      abWrite;
    logic      aluOutWrite;
    aluOp_t    aluOp;
    aluSrcA_t  aluSrcA;
    aluSrcB_t  aluSrcB;
    regDst_t   regDst;
    memToReg_t memToReg;
    pcSource_t pcSource;
  } ctrlWord_t;

endpackage

//--- rtl/ctrlEncoder.sv
`include "ctrl_cfg.svh"

module ctrlEncoder (
  input  ctrl_pkg::phase_t    phase,
  output ctrl_pkg::ctrlWord_t ctrl
);

  localparam logic [`STEP_W-1:0] irStep = `STEP_W'(`FETCH_READ_CYCLES);
  localparam logic [`STEP_W-1:0] abStep = `STEP_W'(`FETCH_READ_CYCLES + 1);

  logic isAddi;
  logic isSub;

  assign isAddi = (phase.instrClass == ctrl_pkg::CLS_ADDI);
  assign isSub  = (phase.instrClass == ctrl_pkg::CLS_SUB);

  always_comb begin
    ctrl = '0;  // idle word, all strobes low

    case (phase.stage)
      ctrl_pkg::STG_FETCH: begin
        if (phase.step < irStep) begin
          // memory read in progress, PC + 4 into ALUOut
          ctrl.aluOutWrite = 1'b1;
          ctrl.aluOp       = ctrl_pkg::ALU_ADD;
          ctrl.aluSrcA     = ctrl_pkg::SRCA_PC;
          ctrl.aluSrcB     = ctrl_pkg::SRCB_FOUR;
          ctrl.pcSource    = ctrl_pkg::PCS_ALURESULT;
        end else if (phase.step == irStep) begin
          ctrl.pcWrite  = 1'b1;
          ctrl.irWrite  = 1'b1;
          ctrl.pcSource = ctrl_pkg::PCS_ALUOUT; // PC + 4 held in ALUOut
        end else if (phase.step == abStep) begin
          ctrl.abWrite = 1'b1; // register file read into A and B
        end
      end

      ctrl_pkg::STG_EXEC: begin
        ctrl.aluOutWrite = 1'b1;
        ctrl.aluSrcA     = ctrl_pkg::SRCA_A;
        if (isSub) begin
          ctrl.aluOp = ctrl_pkg::ALU_SUB;
        end else begin
          ctrl.aluOp = ctrl_pkg::ALU_ADD;
        end
        if (isAddi) begin
          ctrl.aluSrcB = ctrl_pkg::SRCB_IMM;
        end else begin
          ctrl.aluSrcB = ctrl_pkg::SRCB_B;
        end
      end

      // result from ALUOut into the register file
      ctrl_pkg::STG_WRITE: begin
        ctrl.regWrite = 1'b1;
        ctrl.memToReg = ctrl_pkg::WB_ALUOUT;
        if (isAddi) begin
          ctrl.regDst = ctrl_pkg::DST_RT;  // I-type target
        end else begin
          ctrl.regDst = ctrl_pkg::DST_RD;
        end
      end

      // reset, decode and done keep the idle word
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

//--- rtl/ctrlUnit.sv
`include "ctrl_cfg.svh"

module ctrlUnit (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [`OPCODE_W-1:0] opcode,  // from IR
  input  logic [`FUNCT_W-1:0]  funct,
  output ctrl_pkg::ctrlWord_t  ctrl
);

  ctrl_pkg::instrClass_t instrClass;
  ctrl_pkg::phase_t      phase;

  instrDecoder instrDecoder_inst (
    .opcode     (opcode),
    .funct      (funct),
    .instrClass (instrClass)
  );

  // the only registered block
  phaseSequencer phaseSequencer_inst (
    .clk        (clk),
    .reset      (reset),
    .instrClass (instrClass),
    .phase      (phase)
  );

  ctrlEncoder ctrlEncoder_inst (
    .phase (phase),
    .ctrl  (ctrl)
  );

endmodule

//--- rtl/instrDecoder.sv
`include "ctrl_cfg.svh"

module instrDecoder (
  input  logic [`OPCODE_W-1:0]  opcode,
  input  logic [`FUNCT_W-1:0]   funct,
  output ctrl_pkg::instrClass_t instrClass
);

  logic isRType;
  logic isAddi;

  assign isRType = (opcode == `OP_RTYPE);
  assign isAddi  = (opcode == `OP_ADDI);

  // funct only matters for R-type
  always_comb begin
    instrClass = ctrl_pkg::CLS_NONE;
    if (isRType) begin
      case (funct)
        `FN_ADD: instrClass = ctrl_pkg::CLS_ADD;
        `FN_SUB: instrClass = ctrl_pkg::CLS_SUB;
        default: instrClass = ctrl_pkg::CLS_NONE; // other R-type ops
      endcase
    end else if (isAddi) begin
      instrClass = ctrl_pkg::CLS_ADDI;
    end
  end

endmodule

//--- rtl/phaseSequencer.sv
`include "ctrl_cfg.svh"

module phaseSequencer (
  input  logic                  clk,
  input  logic                  reset,
  input  ctrl_pkg::instrClass_t instrClass,
  output ctrl_pkg::phase_t      phase
);

  // fetch runs read steps, then the PC/IR step, then the A/B step
  localparam logic [`STEP_W-1:0] lastFetchStep = `STEP_W'(`FETCH_READ_CYCLES + 1);

  ctrl_pkg::phase_t phaseNext;

  always_comb begin
    phaseNext = phase;
    phaseNext.step = '0;  // only fetch counts steps

    case (phase.stage)
      // one idle cycle after reset before fetch begins
      ctrl_pkg::STG_RESET: begin
        phaseNext.stage = ctrl_pkg::STG_FETCH;
      end

      ctrl_pkg::STG_FETCH: begin
        if (phase.step == lastFetchStep) begin
          phaseNext.stage = ctrl_pkg::STG_DECODE;
        end else begin
          phaseNext.step = phase.step + `STEP_W'(1);
        end
      end

      // IR is stable by now, sample the class
      ctrl_pkg::STG_DECODE: begin
        phaseNext.instrClass = instrClass;
        if (instrClass == ctrl_pkg::CLS_NONE) begin
          phaseNext.stage = ctrl_pkg::STG_FETCH; // unsupported, nothing written
        end else begin
          phaseNext.stage = ctrl_pkg::STG_EXEC;
        end
      end

      ctrl_pkg::STG_EXEC: begin
        phaseNext.stage = ctrl_pkg::STG_WRITE;
      end

      ctrl_pkg::STG_WRITE: begin
        phaseNext.stage = ctrl_pkg::STG_DONE;
      end

      ctrl_pkg::STG_DONE: begin
        phaseNext.stage = ctrl_pkg::STG_FETCH;
      end

      default: begin
        phaseNext.stage = ctrl_pkg::STG_RESET; // recover from illegal encodings
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase.stage      <= ctrl_pkg::STG_RESET;
      phase.step       <= '0;
      phase.instrClass <= ctrl_pkg::CLS_NONE;
    end else begin
      phase <= phaseNext;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module ctrlUnit_tb -f verilog.f -o simv \
  && ./obj_dir/simv | tee /dev/stderr | grep -qxF '*** PASSED ***' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tb/ctrlUnit_checker.sv
module ctrlUnit_checker (
  input logic                clk,
  input logic                reset,
  input ctrl_pkg::ctrlWord_t ctrl
);

  timeunit 1ns;
  timeprecision 100ps;

  // IR load always comes with the PC update
  irImpliesPc: assert property (
    @(posedge clk) disable iff (reset)
      ctrl.irWrite |-> ctrl.pcWrite
  ) else $error("irWrite raised without pcWrite");

  // write-back reads ALUOut, so it must not be reloaded at the same time
  noRegAndAluOut: assert property (
    @(posedge clk) disable iff (reset)
      !(ctrl.regWrite && ctrl.aluOutWrite)
  ) else $error("regWrite and aluOutWrite in the same cycle");

  // done step follows the write step
  idleAfterWrite: assert property (
    @(posedge clk) disable iff (reset)
      ctrl.regWrite |=> (ctrl == '0)
  ) else $error("control word not idle after regWrite");

endmodule

//--- tb/ctrlUnit_tb.sv
`include "ctrl_cfg.svh"

module ctrlUnit_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clkPeriod   = 4;
  localparam int resetCycles = 16;
  localparam int tableSize   = 5;
  localparam int randomCount = 20;
  localparam int numEntries  = tableSize + randomCount;
  localparam int maxGap      = 12;  // longest legal gap is 9
  localparam int randSeed    = 50628;

  // one instruction and what the control unit should do with it
  typedef struct packed {
    logic [`OPCODE_W-1:0]  opcode;
    logic [`FUNCT_W-1:0]   funct;
    ctrl_pkg::instrClass_t cls;
    logic [3:0]            cycles;  // irWrite to next irWrite
    ctrl_pkg::aluOp_t      aluOp;
    ctrl_pkg::aluSrcB_t    aluSrcB;
    ctrl_pkg::regDst_t     regDst;
  } stimEntry_t;

  logic                 clk;
  logic                 reset;
  logic [`OPCODE_W-1:0] opcode;
  logic [`FUNCT_W-1:0]  funct;
  ctrl_pkg::ctrlWord_t  ctrl;

  stimEntry_t stimTable [tableSize];
  int mismatchCount = 0;
  int otherCount = 0;

  ctrlUnit ctrlUnit_inst (
    .clk    (clk),
    .reset  (reset),
    .opcode (opcode),
    .funct  (funct),
    .ctrl   (ctrl)
  );

  bind ctrlUnit ctrlUnit_checker ctrlUnit_checker_inst (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic loadTable();
    stimTable[0] = '{`OP_RTYPE, `FN_ADD, ctrl_pkg::CLS_ADD, 4'd9,
                     ctrl_pkg::ALU_ADD, ctrl_pkg::SRCB_B, ctrl_pkg::DST_RD};
    stimTable[1] = '{`OP_RTYPE, `FN_SUB, ctrl_pkg::CLS_SUB, 4'd9,
                     ctrl_pkg::ALU_SUB, ctrl_pkg::SRCB_B, ctrl_pkg::DST_RD};
    stimTable[2] = '{`OP_ADDI, 6'b010101, ctrl_pkg::CLS_ADDI, 4'd9,
                     ctrl_pkg::ALU_ADD, ctrl_pkg::SRCB_IMM, ctrl_pkg::DST_RT};
    // lw opcode, not handled here
    stimTable[3] = '{6'b100011, 6'b000000, ctrl_pkg::CLS_NONE, 4'd6,
                     ctrl_pkg::ALU_NOP, ctrl_pkg::SRCB_B, ctrl_pkg::DST_RT};
    // R-type AND
    stimTable[4] = '{`OP_RTYPE, 6'b100100, ctrl_pkg::CLS_NONE, 4'd6,
                     ctrl_pkg::ALU_NOP, ctrl_pkg::SRCB_B, ctrl_pkg::DST_RT};
  endtask

  // PC + 4 into ALUOut while memory is read
  function automatic ctrl_pkg::ctrlWord_t fetchReadWord();
    ctrl_pkg::ctrlWord_t w;
    w = '0;
    w.aluOutWrite = 1'b1;
    w.aluOp       = ctrl_pkg::ALU_ADD;
    w.aluSrcA     = ctrl_pkg::SRCA_PC;
    w.aluSrcB     = ctrl_pkg::SRCB_FOUR;
    w.pcSource    = ctrl_pkg::PCS_ALURESULT;
    return w;
  endfunction

  function automatic ctrl_pkg::ctrlWord_t irWord();
    ctrl_pkg::ctrlWord_t w;
    w = '0;
    w.pcWrite  = 1'b1;
    w.irWrite  = 1'b1;
    w.pcSource = ctrl_pkg::PCS_ALUOUT;
    return w;
  endfunction

  // k counts cycles after the irWrite cycle of this entry
  function automatic ctrl_pkg::ctrlWord_t expectedAt(stimEntry_t e, int k);
    ctrl_pkg::ctrlWord_t w;
    int total;
    logic supported;
    total = int'(e.cycles);
    supported = (e.cls != ctrl_pkg::CLS_NONE);
    w = '0;
    if (k == 1) begin
      w.abWrite = 1'b1;
    end else if (k == total) begin
      w = irWord();
    end else if (k >= total - `FETCH_READ_CYCLES && k < total) begin
      w = fetchReadWord();
    end else if (supported && k == 3) begin
      w.aluOutWrite = 1'b1;  // execute
      w.aluOp       = e.aluOp;
      w.aluSrcA     = ctrl_pkg::SRCA_A;
      w.aluSrcB     = e.aluSrcB;
    end else if (supported && k == 4) begin
      w.regWrite = 1'b1;  // write-back
      w.memToReg = ctrl_pkg::WB_ALUOUT;
      w.regDst   = e.regDst;
    end
    return w;
  endfunction

  task automatic checkWord(input string what, input ctrl_pkg::ctrlWord_t exp);
    if (ctrl !== exp) begin
      mismatchCount++;
      $display("Mismatch at %0t ns: %s, expected ctrl %h, got %h", $time, what, exp, ctrl);
    end
  endtask

  // starts at the falling edge inside an irWrite cycle
  task automatic runEntry(input stimEntry_t e, input int num);
    int k;
    @(posedge clk);
    opcode <= e.opcode;
    funct  <= e.funct;
    k = 0;
    do begin
      @(negedge clk);
      k++;
      checkWord($sformatf("entry %0d, cycle %0d", num, k), expectedAt(e, k));
      if (k == 2 && ctrlUnit_inst.instrClass !== e.cls) begin
        mismatchCount++;
        $display("Mismatch at %0t ns: entry %0d decoded as class %0d, expected %0d",
                 $time, num, ctrlUnit_inst.instrClass, e.cls);
      end
    end while (ctrl.irWrite !== 1'b1 && k < maxGap);

    if (ctrl.irWrite !== 1'b1) begin
      otherCount++;
      $display("Entry %0d: no irWrite pulse within %0d cycles", num, maxGap);
    end else if (k != int'(e.cycles)) begin
      mismatchCount++;
      $display("Mismatch at %0t ns: entry %0d took %0d cycles, expected %0d",
               $time, num, k, e.cycles);
    end
  endtask

  task automatic finishRun();
    $display("Error count: %0d mismatches, %0d other failures", mismatchCount, otherCount);
    if (mismatchCount == 0 && otherCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  initial begin
    int i;
    int unsigned pick;
    void'($urandom(randSeed));
    loadTable();
    reset  = 1'b1;
    opcode = '0;
    funct  = '0;

    // last pass is the idle cycle right after reset drops
    for (i = 0; i < resetCycles; i++) begin
      @(posedge clk);
      if (i == resetCycles - 1) begin
        reset <= 1'b0;
      end
      @(negedge clk);
      checkWord($sformatf("reset cycle %0d", i), '0);
    end

    for (i = 0; i < `FETCH_READ_CYCLES; i++) begin
      @(negedge clk);
      checkWord($sformatf("first fetch read %0d", i), fetchReadWord());
    end
    @(negedge clk);
    checkWord("first PC/IR write", irWord());

    for (i = 0; i < tableSize; i++) begin
      runEntry(stimTable[i], i);
    end
    for (i = 0; i < randomCount; i++) begin
      pick = $urandom % tableSize;
      runEntry(stimTable[pick], tableSize + i);
    end

    finishRun();
  end

  // watchdog
  initial begin
    repeat (numEntries * 9 + 40) @(posedge clk);
    otherCount++;
    $display("Timeout: simulation did not finish within %0d cycles", numEntries * 9 + 40);
    finishRun();
  end

endmodule

//--- verilog.f
+incdir+common
common/ctrl_pkg.sv
rtl/instrDecoder.sv
rtl/phaseSequencer.sv
rtl/ctrlEncoder.sv
rtl/ctrlUnit.sv
tb/ctrlUnit_checker.sv
tb/ctrlUnit_tb.sv
